//--- include/vga_defs_defs.svh
`ifndef VGA_DEFS_DEFS_SVH
`define VGA_DEFS_DEFS_SVH

// 800x600 at 60 Hz, 40 MHz pixel clock.
`define HOR_PIXELS   800
`define VER_PIXELS   600

`define HOR_TOTAL    1056
`define VER_TOTAL    628

// Sync pulse runs from start up to but not including end.
`define HSYNC_START  840
`define HSYNC_END    968
`define VSYNC_START  601
`define VSYNC_END    605

// First screen row of the ground.
`define GROUND_Y     500

`define PROJ_RADIUS  15

`define SKY_RGB      12'h8CF
`define GROUND_RGB   12'h0A0
`define BORDER_RGB   12'hFFF

`endif

//--- design/vga_pkg.sv
package vga_pkg;

    // Width of the horizontal and vertical pixel counters.
    typedef logic [10:0] vga_cnt_t;

    // One sample of the pixel stream, taken once per pixel clock.
    // Every stage forwards the whole record so that counters, syncs
    // and colour stay aligned through the pipeline.
    typedef struct packed {
        vga_cnt_t    hcount;
        vga_cnt_t    vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        // 4 bits per colour, red in the top nibble.
        logic [11:0] rgb;
    } vga_sig_t;

endpackage

//--- design/game_pkg.sv
package game_pkg;

    // Game coordinate in pixels.
    typedef logic [11:0] coord_t;

    // 12-bit colour, red in bits 11:8, green in 7:4, blue in 3:0.
    typedef logic [11:0] rgb_t;

    // Position of one projectile in game space.
    // x counts from the left edge, y counts up from the bottom edge.
    typedef struct packed {
        logic   active;
        coord_t x;
        coord_t y;
    } obj_pos_t;

endpackage

//--- design/vga_timing.sv
`timescale 1ns/1ps

`include "vga_defs_defs.svh"

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output vga_pkg::vga_sig_t  vga_out
);

    import vga_pkg::*;

    localparam vga_cnt_t H_LAST = vga_cnt_t'(`HOR_TOTAL - 1);
    localparam vga_cnt_t V_LAST = vga_cnt_t'(`VER_TOTAL - 1);

    vga_cnt_t h_next;
    vga_cnt_t v_next;

    // Next counter values, so every output field comes from one register stage.
    always_comb begin
        if (vga_out.hcount == H_LAST) begin
            h_next = '0;
            if (vga_out.vcount == V_LAST) begin
                v_next = '0;
            end else begin
                v_next = vga_out.vcount + 1'b1;
            end
        end else begin
            h_next = vga_out.hcount + 1'b1;
            v_next = vga_out.vcount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= h_next;
            vga_out.vcount <= v_next;
            vga_out.hsync  <= (h_next >= `HSYNC_START) && (h_next < `HSYNC_END);
            vga_out.vsync  <= (v_next >= `VSYNC_START) && (v_next < `VSYNC_END);
            vga_out.hblnk  <= (h_next >= `HOR_PIXELS);
            vga_out.vblnk  <= (v_next >= `VER_PIXELS);
            vga_out.rgb    <= '0;
        end
    end

    // Counter never leaves the line period.
    assert property (@(posedge clk) disable iff (rst)
        vga_out.hcount < `HOR_TOTAL)
    else $error("vga_timing: hcount %0d out of range", vga_out.hcount);

endmodule

//--- design/draw_background.sv
`timescale 1ns/1ps

`include "vga_defs_defs.svh"

module draw_background (
    input  logic               clk,
    input  logic               rst,
    input  vga_pkg::vga_sig_t  vga_in,
    output vga_pkg::vga_sig_t  vga_out
);

    import game_pkg::*;

    rgb_t rgb_nxt;
    logic on_border;

    // Outermost visible rows and columns.
    assign on_border = (vga_in.hcount == 0)
                    || (vga_in.hcount == `HOR_PIXELS - 1)
                    || (vga_in.vcount == 0)
                    || (vga_in.vcount == `VER_PIXELS - 1);

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;
        end else if (on_border) begin
            rgb_nxt = `BORDER_RGB;
        end else if (vga_in.vcount >= `GROUND_Y) begin
            rgb_nxt = `GROUND_RGB;
        end else begin
            rgb_nxt = `SKY_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

//--- design/draw_projectile.sv
`timescale 1ns/1ps

`include "vga_defs_defs.svh"

module draw_projectile #(
    parameter game_pkg::rgb_t COLOR = 12'hF00
) (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::obj_pos_t pos,
    input  vga_pkg::vga_sig_t  vga_in,
    output vga_pkg::vga_sig_t  vga_out
);

    import vga_pkg::*;

    localparam logic signed [13:0] RADIUS    = 14'(`PROJ_RADIUS);
    localparam logic signed [13:0] SCREEN_H  = 14'(`VER_PIXELS);
    localparam logic signed [27:0] RADIUS_SQ = 28'(`PROJ_RADIUS * `PROJ_RADIUS);

    vga_sig_t                 vga_d;
    logic                     active_q;
    logic signed [13:0]       ctr_x;
    logic signed [13:0]       ctr_y;
    logic signed [13:0]       dx;
    logic signed [13:0]       dy;
    logic signed [27:0]       dist_sq;
    logic                     hit;

    // First cycle. Hold the sample and turn the game position into a screen centre.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_d    <= '0;
            active_q <= 1'b0;
        end else begin
            vga_d    <= vga_in;
            active_q <= pos.active;
        end
    end

    // Game y grows upwards, screen y grows downwards.
    always_ff @(posedge clk) begin
        ctr_x <= $signed({2'b00, pos.x}) - RADIUS;
        ctr_y <= SCREEN_H - $signed({2'b00, pos.y}) + RADIUS;
    end

    // Second cycle. Distance test against the delayed pixel.
    always_comb begin
        dx      = $signed({3'b000, vga_d.hcount}) - ctr_x;
        dy      = $signed({3'b000, vga_d.vcount}) - ctr_y;
        dist_sq = dx * dx + dy * dy;
        hit     = active_q && (dist_sq <= RADIUS_SQ);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_d;
            if (hit) begin
                vga_out.rgb <= COLOR;
            end
        end
    end

    // Pixel position stays aligned with the two-cycle latency.
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(rst, 2) |-> vga_out.hcount == $past(vga_in.hcount, 2))
    else $error("draw_projectile: hcount misaligned");

endmodule

//--- design/vga_frame_top.sv
`timescale 1ns/1ps

module vga_frame_top (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::obj_pos_t cat_pos,
    input  game_pkg::obj_pos_t dog_pos,
    output vga_pkg::vga_sig_t  vga_out
);

    import vga_pkg::*;

    vga_sig_t vga_tim;
    vga_sig_t vga_bg;
    vga_sig_t vga_cat;

    vga_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .vga_out (vga_tim)
    );

    draw_background u_background (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    // Cat shot in red.
    draw_projectile #(
        .COLOR (12'hF00)
    ) u_cat_shot (
        .clk     (clk),
        .rst     (rst),
        .pos     (cat_pos),
        .vga_in  (vga_bg),
        .vga_out (vga_cat)
    );

    // Dog shot in blue, drawn last so it covers the cat where they overlap.
    draw_projectile #(
        .COLOR (12'h00F)
    ) u_dog_shot (
        .clk     (clk),
        .rst     (rst),
        .pos     (dog_pos),
        .vga_in  (vga_cat),
        .vga_out (vga_out)
    );

endmodule

//--- verification/vga_frame_tb.sv
`timescale 1ns/1ps

`include "vga_defs_defs.svh"

module vga_frame_tb;

    import vga_pkg::*;
    import game_pkg::*;

    localparam int   FRAME_CYCLES = `HOR_TOTAL * `VER_TOTAL;
    localparam int   RADIUS       = `PROJ_RADIUS;
    localparam rgb_t CAT_RGB      = 12'hF00;
    localparam rgb_t DOG_RGB      = 12'h00F;

    logic        clk;
    logic        rst;
    obj_pos_t    cat_pos;
    obj_pos_t    dog_pos;
    vga_sig_t    vga_out;

    logic [15:0] lfsr;
    int          frames_started;

    vga_frame_top u_vga_frame_top (
        .clk     (clk),
        .rst     (rst),
        .cat_pos (cat_pos),
        .dog_pos (dog_pos),
        .vga_out (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic in_circle(input int hc, input int vc, input obj_pos_t p);
        int cx;
        int cy;
        int dx;
        int dy;
        // Game y is measured up from the bottom, screen rows count down.
        cx = int'(p.x) - RADIUS;
        cy = `VER_PIXELS - int'(p.y) + RADIUS;
        dx = hc - cx;
        dy = vc - cy;
        return p.active && (dx * dx + dy * dy <= RADIUS * RADIUS);
    endfunction

    function automatic rgb_t expected_rgb(input int hc, input int vc, input logic blank,
                                          input obj_pos_t cat, input obj_pos_t dog);
        rgb_t c;
        if (blank) begin
            c = '0;
        end else if (hc == 0 || hc == `HOR_PIXELS - 1 || vc == 0 || vc == `VER_PIXELS - 1) begin
            c = `BORDER_RGB;
        end else if (vc >= `GROUND_Y) begin
            c = `GROUND_RGB;
        end else begin
            c = `SKY_RGB;
        end
        // The dog is painted after the cat.
        if (in_circle(hc, vc, cat)) begin
            c = CAT_RGB;
        end
        if (in_circle(hc, vc, dog)) begin
            c = DOG_RGB;
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic wait_vblnk(input logic level);
        int n;
        n = 0;
        while (vga_out.vblnk !== level && n < FRAME_CYCLES + 100) begin
            @(negedge clk);
            n++;
        end
        if (vga_out.vblnk !== level) begin
            $display("Timed out after %0d cycles waiting for vblnk to become %0b", n, level);
            $display(">>> FAIL");
            $fatal(1, "Wait timeout");
        end
    endtask

    task automatic load_frame_positions(input int f);
        int   v;
        logic overlap;
        case (f)
            0: begin
                cat_pos = '0;
                dog_pos = '0;
            end
            1: begin
                // Circle crosses the ground line.
                cat_pos.active = 1'b1;
                cat_pos.x      = 12'd200;
                cat_pos.y      = 12'd110;
                dog_pos        = '0;
            end
            default: begin
                take_bits(9, v);
                cat_pos.x = 12'(30 + v);
                take_bits(9, v);
                cat_pos.y = 12'(31 + v);
                take_bits(1, v);
                overlap = (f == 2) || (v == 1);
                if (overlap) begin
                    take_bits(4, v);
                    dog_pos.x = cat_pos.x + 12'(v);
                    take_bits(4, v);
                    dog_pos.y = cat_pos.y + 12'(v);
                end else begin
                    take_bits(9, v);
                    dog_pos.x = 12'(30 + v);
                    take_bits(9, v);
                    dog_pos.y = 12'(31 + v);
                end
                if (f == 2) begin
                    cat_pos.active = 1'b1;
                    dog_pos.active = 1'b1;
                end else begin
                    take_bits(1, v);
                    cat_pos.active = v[0];
                    take_bits(1, v);
                    dog_pos.active = v[0];
                end
            end
        endcase
    endtask

    initial begin : stimulus
        rst            = 1'b1;
        cat_pos        = '0;
        dog_pos        = '0;
        lfsr           = 16'd88;
        frames_started = 0;
        load_frame_positions(0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // New positions go in while the output is in vertical blanking.
        for (int f = 0; f < 4; f++) begin
            if (f > 0) begin
                load_frame_positions(f);
            end
            wait_vblnk(1'b0);
            wait_vblnk(1'b1);
        end
        if (frames_started == 4) begin
            $display(">>> PASS");
        end else begin
            $display("Saw %0d frame starts instead of 4", frames_started);
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : compare_outputs
        vga_sig_t s;
        int       after_rst;
        int       prev_hc;
        int       prev_vc;
        int       exp_hc;
        int       exp_vc;
        logic     blank;
        obj_pos_t frame_cat;
        obj_pos_t frame_dog;
        after_rst = -1;
        prev_hc   = 0;
        prev_vc   = 0;
        frame_cat = '0;
        frame_dog = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                after_rst = 0;
            end else if (after_rst >= 0) begin
                after_rst++;
            end
            @(negedge clk);
            s = vga_out;
            if (after_rst == 0 || after_rst == 1) begin
                check_value("vga_out", 64'(s), 64'(0));
            end else if (after_rst >= 5) begin
                // Five stages of flush, then the first real sample is pixel 0,0.
                if (after_rst == 5) begin
                    exp_hc = 0;
                    exp_vc = 0;
                end else begin
                    exp_hc = (prev_hc + 1) % `HOR_TOTAL;
                    exp_vc = prev_vc;
                    if (exp_hc == 0) begin
                        exp_vc = (prev_vc + 1) % `VER_TOTAL;
                    end
                end
                check_value("hcount", 64'(s.hcount), 64'(exp_hc));
                check_value("vcount", 64'(s.vcount), 64'(exp_vc));
                check_value("hsync", 64'(s.hsync),
                            64'((exp_hc >= `HSYNC_START) && (exp_hc < `HSYNC_END)));
                check_value("vsync", 64'(s.vsync),
                            64'((exp_vc >= `VSYNC_START) && (exp_vc < `VSYNC_END)));
                check_value("hblnk", 64'(s.hblnk), 64'(exp_hc >= `HOR_PIXELS));
                check_value("vblnk", 64'(s.vblnk), 64'(exp_vc >= `VER_PIXELS));
                if (exp_hc == 0 && exp_vc == 0) begin
                    frame_cat = cat_pos;
                    frame_dog = dog_pos;
                    frames_started++;
                end
                blank = (exp_hc >= `HOR_PIXELS) || (exp_vc >= `VER_PIXELS);
                check_value("rgb", 64'(s.rgb),
                            64'(expected_rgb(exp_hc, exp_vc, blank, frame_cat, frame_dog)));
                prev_hc = exp_hc;
                prev_vc = exp_vc;
            end
        end
    end

endmodule

//--- files.f
+incdir+include
design/vga_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/draw_background.sv
design/draw_projectile.sv
design/vga_frame_top.sv
verification/vga_frame_tb.sv

//--- Makefile
SIM       := verilator
TOP       := vga_frame_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing -Wno-fatal -j 0

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BINARY    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
